//--- fpm_cfg_pkg.sv
package fpm_cfg_pkg;

	// exponent path widths
	localparam int EXP_W = 8;
	localparam int EXT_W = 10;
	localparam int CNT_W = 6;

	// mantissa length in bits, beyond it the smaller operand is lost
	localparam int ALIGN_LIMIT = 40;

	// fixed mantissa step counts
	localparam int MUL_STEPS = 40;
	localparam int DIV_STEPS = 41;

	// credit depths
	localparam int IN_DEPTH = 2;
	localparam int OUT_CREDITS = 2;

	// derived widths and sized constants
	localparam int Q_PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
	localparam int Q_CNT_W = $clog2(IN_DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	localparam logic [Q_PTR_W-1:0] Q_LAST = Q_PTR_W'(IN_DEPTH - 1);
	localparam logic [CRD_W-1:0] CRD_INIT = CRD_W'(OUT_CREDITS);
	localparam logic [CNT_W-1:0] MUL_LOAD = CNT_W'(MUL_STEPS);
	localparam logic [CNT_W-1:0] DIV_LOAD = CNT_W'(DIV_STEPS);
	localparam logic [EXT_W-1:0] ALIGN_EXT = EXT_W'(ALIGN_LIMIT);

endpackage

//--- fpm_types_pkg.sv
package fpm_types_pkg;

	// floating opcodes handled by the exponent path
	typedef enum logic [1:0] {
		opc_af = 2'd0,
		opc_sf = 2'd1,
		opc_mf = 2'd2,
		opc_df = 2'd3
	} fp_opc_t;

	// operation as it enters the unit
	typedef struct packed {
		fp_opc_t opc;
		logic signed [fpm_cfg_pkg::EXP_W-1:0] exp_a;
		logic signed [fpm_cfg_pkg::EXP_W-1:0] exp_b;
	} fp_op_t;

	// result record sent downstream
	typedef struct packed {
		fp_opc_t opc;
		logic signed [fpm_cfg_pkg::EXP_W-1:0] exp;
		logic [fpm_cfg_pkg::CNT_W-1:0] steps;
		// difference reaches the alignment limit
		logic g;
		// T denormalized, exp_a is the smaller one
		logic wdt;
		// fi1 / fi2 interrupt flags
		logic ovf;
		logic unf;
	} fp_res_t;

	// adder stage towards the sequencer
	typedef struct packed {
		fp_res_t res;
		logic [fpm_cfg_pkg::CNT_W-1:0] load_cnt;
	} fp_stage_t;

endpackage

//--- fpm_op_queue.sv
`timescale 1ns/1ns

module fpm_op_queue (
	input logic wdtwtg_clk,
	input logic _0_f,
	input logic op_valid,
	input fpm_types_pkg::fp_op_t op,
	input logic q_pop,
	output fpm_types_pkg::fp_op_t q_head,
	output logic q_empty,
	output logic op_credit
);

	fpm_types_pkg::fp_op_t mem [fpm_cfg_pkg::IN_DEPTH];

	logic [fpm_cfg_pkg::Q_PTR_W-1:0] wr_ptr;
	logic [fpm_cfg_pkg::Q_PTR_W-1:0] rd_ptr;
	logic [fpm_cfg_pkg::Q_CNT_W-1:0] fill;

	// wrap at the last entry, depth need not be a power of two
	function automatic logic [fpm_cfg_pkg::Q_PTR_W-1:0] ptr_next(
		input logic [fpm_cfg_pkg::Q_PTR_W-1:0] p
	);
		if (p == fpm_cfg_pkg::Q_LAST) return '0;
		return p + 1'b1;
	endfunction

	always_ff @(posedge wdtwtg_clk, posedge _0_f) begin
		if (_0_f) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			op_credit <= 1'b0;
		end else begin
			// one credit back per entry popped
			op_credit <= q_pop;
			if (op_valid) wr_ptr <= ptr_next(wr_ptr);
			if (q_pop) rd_ptr <= ptr_next(rd_ptr);
			case ({op_valid, q_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// upstream only sends while holding credit, so never full here
	always_ff @(posedge wdtwtg_clk) begin
		if (op_valid) mem[wr_ptr] <= op;
	end

	assign q_head = mem[rd_ptr];
	assign q_empty = (fill == '0);

endmodule

//--- fpm_exp_adder.sv
`timescale 1ns/1ns

module fpm_exp_adder (
	input logic wdtwtg_clk,
	input logic _0_f,
	input logic add_go,
	input fpm_types_pkg::fp_op_t head,
	input logic take,
	output logic stage_valid,
	output fpm_types_pkg::fp_stage_t stage
);

	logic [fpm_cfg_pkg::EXT_W-1:0] ext_a;
	logic [fpm_cfg_pkg::EXT_W-1:0] ext_b;
	logic [fpm_cfg_pkg::EXT_W-1:0] ext_r;
	logic [fpm_cfg_pkg::EXT_W-1:0] mag;
	logic neg;
	logic big;
	fpm_types_pkg::fp_stage_t nxt;

	// sign extend both exponents into the wide adder
	assign ext_a = {{(fpm_cfg_pkg::EXT_W - fpm_cfg_pkg::EXP_W){head.exp_a[fpm_cfg_pkg::EXP_W-1]}},
		head.exp_a};
	assign ext_b = {{(fpm_cfg_pkg::EXT_W - fpm_cfg_pkg::EXP_W){head.exp_b[fpm_cfg_pkg::EXP_W-1]}},
		head.exp_b};

	// sum for multiply, difference otherwise
	assign ext_r = (head.opc == fpm_types_pkg::opc_mf) ? ext_a + ext_b : ext_a - ext_b;
	assign neg = ext_r[fpm_cfg_pkg::EXT_W-1];
	assign mag = neg ? -ext_r : ext_r;
	assign big = (mag >= fpm_cfg_pkg::ALIGN_EXT);

	always_comb begin
		nxt = '0;
		nxt.res.opc = head.opc;
		case (head.opc)
			fpm_types_pkg::opc_af, fpm_types_pkg::opc_sf: begin
				nxt.res.g = big;
				nxt.res.wdt = neg;
				// result takes the larger exponent
				nxt.res.exp = neg ? head.exp_b : head.exp_a;
				// nothing to shift once the operand is gone
				nxt.load_cnt = big ? '0 : mag[fpm_cfg_pkg::CNT_W-1:0];
			end
			default: begin
				nxt.res.exp = ext_r[fpm_cfg_pkg::EXP_W-1:0];
				// out of range when the bits above the sign bit disagree with it
				nxt.res.ovf = ~neg &
					(ext_r[fpm_cfg_pkg::EXT_W-2:fpm_cfg_pkg::EXP_W-1] != '0);
				nxt.res.unf = neg &
					(ext_r[fpm_cfg_pkg::EXT_W-2:fpm_cfg_pkg::EXP_W-1] != '1);
				if (head.opc == fpm_types_pkg::opc_mf) begin
					nxt.load_cnt = fpm_cfg_pkg::MUL_LOAD;
				end else begin
					nxt.load_cnt = fpm_cfg_pkg::DIV_LOAD;
				end
			end
		endcase
		nxt.res.steps = nxt.load_cnt;
	end

	// a new op refills the stage in the same cycle the old one is taken
	always_ff @(posedge wdtwtg_clk, posedge _0_f) begin
		if (_0_f) begin
			stage_valid <= 1'b0;
		end else if (add_go) begin
			stage_valid <= 1'b1;
		end else if (take) begin
			stage_valid <= 1'b0;
		end
	end

	always_ff @(posedge wdtwtg_clk) begin
		if (add_go) stage <= nxt;
	end

endmodule

//--- fpm_fic.sv
`timescale 1ns/1ns

module fpm_fic (
	input logic wdtwtg_clk,
	input logic _0_f,
	input logic cnt_load,
	input logic [fpm_cfg_pkg::CNT_W-1:0] load_val,
	input logic cnt_run,
	output logic cnt_zero
);

	logic [fpm_cfg_pkg::CNT_W-1:0] cnt;

	// load wins over counting
	always_ff @(posedge wdtwtg_clk, posedge _0_f) begin
		if (_0_f) begin
			cnt <= '0;
		end else if (cnt_load) begin
			cnt <= load_val;
		end else if (cnt_run && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	// stops at zero, no wrap
	assign cnt_zero = (cnt == '0);

endmodule

//--- fpm_seq.sv
`timescale 1ns/1ns

module fpm_seq (
	input logic wdtwtg_clk,
	input logic _0_f,
	input logic q_empty,
	output logic q_pop,
	output logic add_go,
	input logic stage_valid,
	input fpm_types_pkg::fp_stage_t stage,
	output logic take,
	output logic cnt_load,
	output logic [fpm_cfg_pkg::CNT_W-1:0] load_val,
	output logic cnt_run,
	input logic cnt_zero,
	input logic res_credit,
	output logic res_valid,
	output fpm_types_pkg::fp_res_t res
);

	typedef enum logic [1:0] {
		st_idle,
		st_count,
		st_done
	} seq_state_t;

	seq_state_t state;
	fpm_types_pkg::fp_res_t rec;
	logic [fpm_cfg_pkg::CRD_W-1:0] credits;

	// stage handed over only when the counter is free
	assign take = (state == st_idle) && stage_valid;

	// refill the adder stage as soon as it frees up
	assign q_pop = ~q_empty && (~stage_valid || take);
	assign add_go = q_pop;

	assign cnt_load = take;
	assign load_val = stage.load_cnt;
	assign cnt_run = (state == st_count);

	// finished record waits here for downstream credit
	assign res_valid = (state == st_done) && (credits != '0);
	assign res = rec;

	always_ff @(posedge wdtwtg_clk, posedge _0_f) begin
		if (_0_f) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (take) state <= st_count;
				end
				st_count: begin
					if (cnt_zero) state <= st_done;
				end
				st_done: begin
					if (res_valid) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// record latched together with the counter load
	always_ff @(posedge wdtwtg_clk) begin
		if (take) rec <= stage.res;
	end

	// downstream buffer slots we may still fill
	always_ff @(posedge wdtwtg_clk, posedge _0_f) begin
		if (_0_f) begin
			credits <= fpm_cfg_pkg::CRD_INIT;
		end else begin
			case ({res_credit, res_valid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- fpm.sv
`timescale 1ns/1ns

module fpm (
	input logic wdtwtg_clk,
	input logic _0_f,
	input logic op_valid,
	input fpm_types_pkg::fp_op_t op,
	output logic op_credit,
	output logic res_valid,
	output fpm_types_pkg::fp_res_t res,
	input logic res_credit
);

	fpm_types_pkg::fp_op_t q_head;
	logic q_empty;
	logic q_pop;

	logic add_go;
	logic take;
	logic stage_valid;
	fpm_types_pkg::fp_stage_t stage;

	logic cnt_load;
	logic [fpm_cfg_pkg::CNT_W-1:0] load_val;
	logic cnt_run;
	logic cnt_zero;

	fpm_op_queue u_queue (
		.wdtwtg_clk(wdtwtg_clk),
		._0_f(_0_f),
		.op_valid(op_valid),
		.op(op),
		.q_pop(q_pop),
		.q_head(q_head),
		.q_empty(q_empty),
		.op_credit(op_credit)
	);

	fpm_exp_adder u_adder (
		.wdtwtg_clk(wdtwtg_clk),
		._0_f(_0_f),
		.add_go(add_go),
		.head(q_head),
		.take(take),
		.stage_valid(stage_valid),
		.stage(stage)
	);

	// shift / step counter
	fpm_fic u_fic (
		.wdtwtg_clk(wdtwtg_clk),
		._0_f(_0_f),
		.cnt_load(cnt_load),
		.load_val(load_val),
		.cnt_run(cnt_run),
		.cnt_zero(cnt_zero)
	);

	fpm_seq u_seq (
		.wdtwtg_clk(wdtwtg_clk),
		._0_f(_0_f),
		.q_empty(q_empty),
		.q_pop(q_pop),
		.add_go(add_go),
		.stage_valid(stage_valid),
		.stage(stage),
		.take(take),
		.cnt_load(cnt_load),
		.load_val(load_val),
		.cnt_run(cnt_run),
		.cnt_zero(cnt_zero),
		.res_credit(res_credit),
		.res_valid(res_valid),
		.res(res)
	);

endmodule

//--- fpm_tb.sv
`timescale 1ns/1ns

module fpm_tb;

	localparam int EMAX = (1 << (fpm_cfg_pkg::EXP_W - 1)) - 1;
	localparam int EMIN = -(1 << (fpm_cfg_pkg::EXP_W - 1));
	localparam int CYC_PER_OP = 50;
	localparam int CYC_SLACK = 200;

	logic wdtwtg_clk;
	logic _0_f;
	logic op_valid;
	fpm_types_pkg::fp_op_t op;
	logic op_credit;
	logic res_valid;
	fpm_types_pkg::fp_res_t res;
	logic res_credit;

	fpm_types_pkg::fp_res_t exp_q[$];
	int n_sent = 0;
	int n_op_cred = 0;
	int n_rcv = 0;
	int n_ret = 0;
	int cycles = 0;
	// 0 withhold, 1 prompt, 2 random dribble
	int cred_mode = 1;

	fpm UUT (
		.wdtwtg_clk(wdtwtg_clk),
		._0_f(_0_f),
		.op_valid(op_valid),
		.op(op),
		.op_credit(op_credit),
		.res_valid(res_valid),
		.res(res),
		.res_credit(res_credit)
	);

	always #2 wdtwtg_clk = ~wdtwtg_clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_res(input fpm_types_pkg::fp_res_t got,
		input fpm_types_pkg::fp_res_t want);
		if (got !== want) begin
			stop_run($sformatf("Error at %0t: result %h, expected %h", $time, got, want));
		end
	endtask

	task automatic check_credit(input logic [fpm_cfg_pkg::CRD_W-1:0] got,
		input logic [fpm_cfg_pkg::CRD_W-1:0] want, input string what);
		if (got !== want) begin
			stop_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, want));
		end
	endtask

	task automatic check_count(input int got, input int want, input string what);
		if (got != want) begin
			stop_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, want));
		end
	endtask

	// expected record from the exponent rules
	task automatic model_op(input fpm_types_pkg::fp_op_t o);
		int a;
		int b;
		int d;
		int mag;
		int n_steps;
		fpm_types_pkg::fp_res_t r;
		a = $signed(o.exp_a);
		b = $signed(o.exp_b);
		r = '0;
		r.opc = o.opc;
		if (o.opc == fpm_types_pkg::opc_af || o.opc == fpm_types_pkg::opc_sf) begin
			d = a - b;
			mag = (d < 0) ? -d : d;
			r.g = (mag >= fpm_cfg_pkg::ALIGN_LIMIT);
			r.wdt = (d < 0);
			r.exp = (d < 0) ? o.exp_b : o.exp_a;
			r.steps = r.g ? '0 : mag[fpm_cfg_pkg::CNT_W-1:0];
		end else begin
			d = (o.opc == fpm_types_pkg::opc_mf) ? a + b : a - b;
			r.exp = d[fpm_cfg_pkg::EXP_W-1:0];
			r.ovf = (d > EMAX);
			r.unf = (d < EMIN);
			if (o.opc == fpm_types_pkg::opc_mf) n_steps = fpm_cfg_pkg::MUL_STEPS;
			else n_steps = fpm_cfg_pkg::DIV_STEPS;
			r.steps = n_steps[fpm_cfg_pkg::CNT_W-1:0];
		end
		exp_q.push_back(r);
	endtask

	// waits for an upstream credit, then one op_valid cycle
	task automatic send_op(input fpm_types_pkg::fp_opc_t opc, input int a, input int b);
		fpm_types_pkg::fp_op_t o;
		o.opc = opc;
		o.exp_a = a[fpm_cfg_pkg::EXP_W-1:0];
		o.exp_b = b[fpm_cfg_pkg::EXP_W-1:0];
		while (n_sent - n_op_cred >= fpm_cfg_pkg::IN_DEPTH) @(negedge wdtwtg_clk);
		model_op(o);
		op = o;
		op_valid = 1'b1;
		n_sent++;
		@(negedge wdtwtg_clk);
		op_valid = 1'b0;
	endtask

	task automatic drain_results();
		while (exp_q.size() != 0 || n_rcv != n_ret) @(negedge wdtwtg_clk);
		repeat (2) @(negedge wdtwtg_clk);
		check_count(n_op_cred, n_sent, "op_credit returns");
		check_credit(UUT.u_seq.credits, fpm_cfg_pkg::CRD_INIT, "output credits after drain");
	endtask

	task automatic test_add_small();
		send_op(fpm_types_pkg::opc_af, 10, 3);
		send_op(fpm_types_pkg::opc_sf, 3, 10);
		send_op(fpm_types_pkg::opc_af, -5, -5);
		send_op(fpm_types_pkg::opc_sf, -20, 15);
		send_op(fpm_types_pkg::opc_af, 0, 39);
		drain_results();
	endtask

	task automatic test_add_far();
		send_op(fpm_types_pkg::opc_af, 40, 0);
		send_op(fpm_types_pkg::opc_sf, -64, -24);
		send_op(fpm_types_pkg::opc_af, 127, -128);
		send_op(fpm_types_pkg::opc_sf, -128, 127);
		drain_results();
	endtask

	task automatic test_mul_div();
		send_op(fpm_types_pkg::opc_mf, 100, 50);
		send_op(fpm_types_pkg::opc_mf, -100, -50);
		send_op(fpm_types_pkg::opc_mf, 64, 63);
		send_op(fpm_types_pkg::opc_df, -128, 1);
		send_op(fpm_types_pkg::opc_df, 100, -50);
		send_op(fpm_types_pkg::opc_df, 5, 7);
		drain_results();
	endtask

	// two results go out, then the unit fills up and stalls
	task automatic test_backpressure();
		int base;
		base = n_rcv;
		cred_mode = 0;
		for (int i = 0; i < 5; i++) send_op(fpm_types_pkg::opc_mf, 3 * i, -i);
		while (n_rcv - base < fpm_cfg_pkg::OUT_CREDITS) @(negedge wdtwtg_clk);
		repeat (100) @(negedge wdtwtg_clk);
		check_count(n_rcv - base, fpm_cfg_pkg::OUT_CREDITS, "results under back-pressure");
		check_credit(UUT.u_seq.credits, '0, "output credits under back-pressure");
		// one op done, one in the adder stage, one left queued
		check_count(n_sent - n_op_cred, 1, "operations held in queue");
		cred_mode = 1;
		drain_results();
	endtask

	task automatic test_random();
		int a;
		int b;
		fpm_types_pkg::fp_opc_t opc;
		cred_mode = 2;
		for (int i = 0; i < 60; i++) begin
			opc = fpm_types_pkg::fp_opc_t'(2'($urandom_range(3)));
			a = int'($urandom_range(255)) + EMIN;
			// half of them close enough to align
			if ($urandom_range(1) == 1) b = a + int'($urandom_range(90)) - 45;
			else b = int'($urandom_range(255)) + EMIN;
			send_op(opc, a, b);
			if ($urandom_range(3) == 0) @(negedge wdtwtg_clk);
		end
		drain_results();
	endtask

	// downstream credit returns
	always @(negedge wdtwtg_clk) begin
		res_credit = 1'b0;
		if (!_0_f && n_rcv > n_ret) begin
			if (cred_mode == 1 || (cred_mode == 2 && $urandom_range(3) == 0)) begin
				res_credit = 1'b1;
				n_ret++;
			end
		end
	end

	always @(posedge wdtwtg_clk) begin
		if (!_0_f && op_credit) begin
			n_op_cred++;
			if (n_op_cred > n_sent) stop_run("op_credit pulsed with no operation outstanding");
		end
		if (!_0_f && res_valid) begin
			if (exp_q.size() == 0) begin
				stop_run("res_valid rose with no operation outstanding");
			end else begin
				check_res(res, exp_q.pop_front());
				n_rcv++;
			end
		end
	end

	always @(posedge wdtwtg_clk) begin
		cycles++;
		if (cycles > CYC_PER_OP * n_sent + CYC_SLACK) begin
			stop_run($sformatf("timeout after %0d cycles, results stopped arriving", cycles));
		end
	end

	initial begin
		void'($urandom(32'hd621e280));
		wdtwtg_clk = 1'b0;
		_0_f = 1'b1;
		op_valid = 1'b0;
		op = '0;
		res_credit = 1'b0;
		repeat (3) @(posedge wdtwtg_clk);
		@(negedge wdtwtg_clk);
		_0_f = 1'b0;
		test_add_small();
		test_add_far();
		test_mul_div();
		test_backpressure();
		test_random();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- fpm.f
fpm_cfg_pkg.sv
fpm_types_pkg.sv
fpm_op_queue.sv
fpm_exp_adder.sv
fpm_fic.sv
fpm_seq.sv
fpm.sv
fpm_tb.sv

//--- run_fpm.sh
#!/bin/sh
rm -rf obj_dir run_fpm.log
verilator --binary --timing -Wno-fatal --top-module fpm_tb -f fpm.f -o fpm_sim \
	&& ./obj_dir/fpm_sim > run_fpm.log 2>&1
cat run_fpm.log 2>/dev/null
grep -qx 'RESULT: PASS' run_fpm.log && exit 0 || exit 1
